//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | awk '{ print } $$0 == "$(PASS_TEXT)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_NS = 2   // 4 ns period
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #HALF_NS clk = ~clk;
    end
endmodule

`default_nettype wire

//--- bench/tb_ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top;
    import ex_pkg::*;

    localparam int WAIT_LIMIT = 100;

    logic    clk, reset, issue, flush;
    alu_op_t op;
    word_t   src_a, src_b;
    shamt_t  sa;
    logic    stall, overflow, result_valid;
    dword_t  result;
    word_t   hi, lo;

    integer  seed = 32'hfb58;
    int      errors = 0;
    int      timeouts = 0;
    word_t   model_hi = '0;
    word_t   model_lo = '0;

    tb_clock u_clock (.clk(clk));

    ex_top dut (
        .clk(clk), .reset(reset), .issue(issue), .op(op), .src_a(src_a), .src_b(src_b),
        .sa(sa), .flush(flush), .stall(stall), .result(result), .overflow(overflow),
        .result_valid(result_valid), .hi(hi), .lo(lo)
    );

    function automatic word_t pick_operand();
        int r;
        r = $random(seed);
        case (r & 7)
            0: return 32'h0;
            1: return 32'h1;
            2: return 32'hffff_ffff;
            3: return 32'h8000_0000;   // most negative
            default: return word_t'($random(seed));
        endcase
    endfunction

    // any code except mult and div including unused ones
    function automatic alu_op_t pick_single_op();
        int r;
        r = $random(seed) & 31;
        if (r >= 20 && r <= 23)
            r = r + 8;
        return alu_op_t'(r);
    endfunction

    function automatic logic is_muldiv(input alu_op_t o);
        return (o == OP_MULT) || (o == OP_MULTU) || (o == OP_DIV) || (o == OP_DIVU);
    endfunction

    task automatic model_op(input alu_op_t o, input word_t a, input word_t b,
                            input shamt_t s, output dword_t res, output logic ovf);
        logic [32:0]        wide;
        logic signed [63:0] aw, bw;
        word_t              qm, rm;
        logic               sgn;
        res = '0;
        ovf = 1'b0;
        sgn = (o == OP_MULT) || (o == OP_DIV);
        case (o)
            OP_AND:    res[31:0] = a & b;
            OP_OR:     res[31:0] = a | b;
            OP_NOR:    res[31:0] = ~(a | b);
            OP_XOR:    res[31:0] = a ^ b;
            OP_ADD, OP_ADDU: begin
                wide      = {a[31], a} + {b[31], b};
                res[31:0] = wide[31:0];
                ovf       = (o == OP_ADD) && (wide[32] != wide[31]);
            end
            OP_SUB, OP_SUBU: begin
                wide      = {a[31], a} - {b[31], b};
                res[31:0] = wide[31:0];
                ovf       = (o == OP_SUB) && (wide[32] != wide[31]);
            end
            OP_SLT:    res[0] = $signed(a) < $signed(b);
            OP_SLTU:   res[0] = a < b;
            OP_SLL:    res[31:0] = b << a[4:0];
            OP_SRL:    res[31:0] = b >> a[4:0];
            OP_SRA:    res[31:0] = $signed(b) >>> a[4:0];
            OP_SLL_SA: res[31:0] = b << s;
            OP_SRL_SA: res[31:0] = b >> s;
            OP_SRA_SA: res[31:0] = $signed(b) >>> s;
            OP_LUI:    res[31:0] = {b[15:0], 16'h0};
            OP_MTHI:   res = {a, model_lo};
            OP_MTLO:   res = {model_hi, a};
            OP_MULT:   res = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
            OP_MULTU:  res = {32'h0, a} * {32'h0, b};
            OP_DIV, OP_DIVU: begin
                if (b == 0) begin
                    qm = '1;
                    if (sgn && (a[31] ^ b[31]))
                        qm = -qm;
                    rm = a;
                end else begin
                    aw = sgn ? {{32{a[31]}}, a} : {32'h0, a};
                    bw = sgn ? {{32{b[31]}}, b} : {32'h0, b};
                    qm = word_t'(aw / bw);   // truncates toward zero
                    rm = word_t'(aw % bw);   // sign of dividend
                end
                res = {rm, qm};
            end
            default:   res[31:0] = a;
        endcase
    endtask

    task automatic commit_hilo(input alu_op_t o, input dword_t res);
        if (o == OP_MTHI || is_muldiv(o))
            model_hi = res[63:32];
        if (o == OP_MTLO || is_muldiv(o))
            model_lo = res[31:0];
    endtask

    task automatic compare(input string name, input dword_t exp, input dword_t got);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // hold issue until the stage takes the instruction
    task automatic send_instr(input alu_op_t o, input word_t a, input word_t b, input shamt_t s);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        issue = 1'b1;
        op    = o;
        src_a = a;
        src_b = b;
        sa    = s;
        @(negedge clk);
        while (stall && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (stall) begin
            timeouts++;
            $display("timeout at %0t: stage never accepted the instruction", $time);
        end
        @(posedge clk);
        #1;
        issue = 1'b0;
    endtask

    task automatic wait_result(output int stalls, output int cycles);
        int n;
        n = 0;
        stalls = 0;
        @(negedge clk);
        while (!result_valid && n < WAIT_LIMIT) begin
            if (stall)
                stalls++;
            @(negedge clk);
            n++;
        end
        cycles = n;
        if (!result_valid) begin
            timeouts++;
            $display("timeout at %0t: no result_valid after %0d cycles", $time, n);
        end
    endtask

    task automatic check_hilo();
        compare("hi", 64'(model_hi), 64'(hi));
        compare("lo", 64'(model_lo), 64'(lo));
    endtask

    task automatic run_op(input alu_op_t o, input word_t a, input word_t b, input shamt_t s);
        dword_t exp;
        logic   exp_ovf;
        int     stalls, cycles, exp_stalls;
        model_op(o, a, b, s, exp, exp_ovf);
        send_instr(o, a, b, s);
        wait_result(stalls, cycles);
        exp_stalls = (o == OP_MULT || o == OP_MULTU) ? MULT_CYCLES : 0;
        if (o != OP_DIV && o != OP_DIVU) begin
            if (stalls != exp_stalls) begin
                errors++;
                $display("FAILED at %0t: stall cycles expected %0d got %0d",
                         $time, exp_stalls, stalls);
            end
            if (cycles != exp_stalls) begin
                errors++;
                $display("FAILED at %0t: cycles before result_valid expected %0d got %0d",
                         $time, exp_stalls, cycles);
            end
        end
        compare("result", exp, result);
        compare("overflow", 64'(exp_ovf), 64'(overflow));
        commit_hilo(o, exp);
        @(negedge clk);
        check_hilo();
    endtask

    // second op waits behind a running mult or div
    task automatic issue_while_stalled(input alu_op_t md, input word_t a, input word_t b,
                                       input alu_op_t o2, input word_t a2, input word_t b2);
        dword_t exp;
        logic   exp_ovf;
        int     stalls, cycles;
        model_op(md, a, b, 5'd0, exp, exp_ovf);
        send_instr(md, a, b, 5'd0);
        issue = 1'b1;
        op    = o2;
        src_a = a2;
        src_b = b2;
        wait_result(stalls, cycles);
        compare("result", exp, result);
        commit_hilo(md, exp);
        model_op(o2, a2, b2, 5'd0, exp, exp_ovf);
        @(posedge clk);
        #1;
        issue = 1'b0;
        @(negedge clk);
        if (!result_valid) begin
            errors++;
            $display("error at %0t: instruction held during stall was lost", $time);
        end
        compare("result", exp, result);
        compare("overflow", 64'(exp_ovf), 64'(overflow));
        commit_hilo(o2, exp);
        @(negedge clk);
        check_hilo();
    endtask

    task automatic flush_in_flight(input alu_op_t o, input word_t a, input word_t b,
                                   input int delay);
        send_instr(o, a, b, 5'd0);
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        flush = 1'b1;
        @(negedge clk);
        if (result_valid) begin
            errors++;
            $display("error at %0t: result_valid high during flush", $time);
        end
        @(posedge clk);
        #1;
        flush = 1'b0;
        @(negedge clk);
        if (stall) begin
            errors++;
            $display("error at %0t: stall still high after flush", $time);
        end
        if (result_valid) begin
            errors++;
            $display("error at %0t: flushed instruction produced a result", $time);
        end
        check_hilo();
        // aborted unit takes a new op right away
        run_op(o, b, a, 5'd0);
    endtask

    initial begin
        alu_op_t o, o2;
        word_t   a, b;
        reset = 1'b1;
        issue = 1'b0;
        flush = 1'b0;
        op    = OP_PASS;
        src_a = '0;
        src_b = '0;
        sa    = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        if (stall || result_valid) begin
            errors++;
            $display("error at %0t: stall or result_valid high after reset", $time);
        end
        check_hilo();

        for (int i = 0; i < 300; i++) begin
            o = pick_single_op();
            a = pick_operand();
            b = pick_operand();
            run_op(o, a, b, shamt_t'($random(seed)));
        end
        for (int i = 0; i < 40; i++) begin
            o = ($random(seed) & 1) ? OP_MULT : OP_MULTU;
            a = pick_operand();
            b = pick_operand();
            run_op(o, a, b, 5'd0);
        end
        run_op(OP_DIV, 32'hffff_fff9, 32'h0, 5'd0);   // zero divisor cases
        run_op(OP_DIVU, 32'h5, 32'h0, 5'd0);
        run_op(OP_DIV, 32'hffff_fff9, 32'h2, 5'd0);
        run_op(OP_DIV, 32'h7, 32'hffff_fffe, 5'd0);
        run_op(OP_DIV, 32'h8000_0000, 32'hffff_ffff, 5'd0);
        for (int i = 0; i < 40; i++) begin
            o = ($random(seed) & 1) ? OP_DIV : OP_DIVU;
            a = pick_operand();
            b = pick_operand();
            run_op(o, a, b, 5'd0);
        end
        for (int i = 0; i < 12; i++) begin
            o = ($random(seed) & 1) ? OP_MTHI : OP_MTLO;
            run_op(o, pick_operand(), 32'h0, 5'd0);
        end
        for (int i = 0; i < 12; i++) begin
            o  = OP_MULT + alu_op_t'($random(seed) & 3);
            o2 = (i % 3 == 0) ? OP_MTLO : pick_single_op();
            a  = pick_operand();
            b  = pick_operand();
            issue_while_stalled(o, a, b, o2, pick_operand(), pick_operand());
        end
        for (int i = 0; i < 12; i++) begin
            o = OP_MULT + alu_op_t'($random(seed) & 3);
            a = pick_operand();
            b = pick_operand();
            flush_in_flight(o, a, b, ($random(seed) & 32'h7fff_ffff) % 6);
        end

        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  e_valid,
    input  wire ex_pkg::alu_op_t e_op,
    input  wire ex_pkg::word_t   e_a,
    input  wire ex_pkg::word_t   e_b,
    input  wire ex_pkg::shamt_t  e_sa,
    input  wire                  e_new,
    input  wire                  flush,
    input  wire ex_pkg::dword_t  hilo,
    muldiv_if.ctrl               mul,
    muldiv_if.ctrl               div,
    output logic                 stall,
    output ex_pkg::dword_t       result,
    output logic                 overflow,
    output logic                 result_valid,
    output logic                 hilo_we_hi,
    output logic                 hilo_we_lo
);
    import ex_pkg::*;

    logic   is_and, is_or, is_nor, is_xor;
    logic   is_add, is_addu, is_sub, is_subu, is_slt, is_sltu;
    logic   is_sll, is_srl, is_sra, is_sll_sa, is_srl_sa, is_sra_sa;
    logic   is_lui, is_pass, is_mthi, is_mtlo;
    logic   is_mult, is_multu, is_div, is_divu, is_md_mul, is_md_div;
    logic   sub_like, cout, slt_bit;
    word_t  adder_b, sum, shl, alu_out;
    shamt_t shamt;
    dword_t shr_wide;
    logic   md_pend, md_done, md_busy;

    assign is_and    = (e_op == OP_AND);
    assign is_or     = (e_op == OP_OR);
    assign is_nor    = (e_op == OP_NOR);
    assign is_xor    = (e_op == OP_XOR);
    assign is_add    = (e_op == OP_ADD);
    assign is_addu   = (e_op == OP_ADDU);
    assign is_sub    = (e_op == OP_SUB);
    assign is_subu   = (e_op == OP_SUBU);
    assign is_slt    = (e_op == OP_SLT);
    assign is_sltu   = (e_op == OP_SLTU);
    assign is_sll    = (e_op == OP_SLL);
    assign is_srl    = (e_op == OP_SRL);
    assign is_sra    = (e_op == OP_SRA);
    assign is_sll_sa = (e_op == OP_SLL_SA);
    assign is_srl_sa = (e_op == OP_SRL_SA);
    assign is_sra_sa = (e_op == OP_SRA_SA);
    assign is_lui    = (e_op == OP_LUI);
    assign is_mthi   = (e_op == OP_MTHI);
    assign is_mtlo   = (e_op == OP_MTLO);
    assign is_mult   = (e_op == OP_MULT);
    assign is_multu  = (e_op == OP_MULTU);
    assign is_div    = (e_op == OP_DIV);
    assign is_divu   = (e_op == OP_DIVU);
    assign is_md_mul = is_mult | is_multu;
    assign is_md_div = is_div | is_divu;

    // unknown codes fall back to pass
    assign is_pass = ~(is_and | is_or | is_nor | is_xor | is_add | is_addu | is_sub
                     | is_subu | is_slt | is_sltu | is_sll | is_srl | is_sra | is_sll_sa
                     | is_srl_sa | is_sra_sa | is_lui | is_mthi | is_mtlo
                     | is_md_mul | is_md_div);

    // shared adder, a + ~b + 1 for compares and subtracts
    assign sub_like      = is_sub | is_subu | is_slt | is_sltu;
    assign adder_b       = e_b ^ {32{sub_like}};
    assign {cout, sum}   = {1'b0, e_a} + {1'b0, adder_b} + {32'b0, sub_like};
    assign slt_bit       = (e_a[31] & ~e_b[31]) | (~(e_a[31] ^ e_b[31]) & sum[31]);
    assign overflow      = e_valid & (is_add | is_sub)
                           & (e_a[31] == adder_b[31]) & (sum[31] != e_a[31]);

    assign shamt    = (is_sll | is_srl | is_sra) ? e_a[4:0] : e_sa;
    assign shl      = e_b << shamt;
    assign shr_wide = {{32{(is_sra | is_sra_sa) & e_b[31]}}, e_b} >> shamt;

    assign alu_out = ({32{is_and}} & (e_a & e_b))
                   | ({32{is_or}}  & (e_a | e_b))
                   | ({32{is_nor}} & ~(e_a | e_b))
                   | ({32{is_xor}} & (e_a ^ e_b))
                   | ({32{is_add | is_addu | is_sub | is_subu}} & sum)
                   | ({32{is_slt}}  & {31'b0, slt_bit})
                   | ({32{is_sltu}} & {31'b0, ~cout})     // borrow means a < b
                   | ({32{is_sll | is_sll_sa}} & shl)
                   | ({32{is_srl | is_sra | is_srl_sa | is_sra_sa}} & shr_wide[31:0])
                   | ({32{is_lui}}  & {e_b[15:0], 16'b0})
                   | ({32{is_pass}} & e_a);

    always_comb begin
        if (is_mthi)
            result = {e_a, hilo[31:0]};
        else if (is_mtlo)
            result = {hilo[63:32], e_a};
        else if (is_md_mul)
            result = mul.result;
        else if (is_md_div)
            result = div.result;
        else
            result = {32'b0, alu_out};
    end

    assign mul.start = e_valid & e_new & is_md_mul;
    assign mul.sign  = is_mult;
    assign mul.a     = e_a;
    assign mul.b     = e_b;
    assign div.start = e_valid & e_new & is_md_div;
    assign div.sign  = is_div;
    assign div.a     = e_a;
    assign div.b     = e_b;

    assign md_done = (is_md_mul & mul.done) | (is_md_div & div.done);
    assign md_busy = (is_md_mul & mul.busy) | (is_md_div & div.busy);

    // unit launched for the op in the stage
    always_ff @(posedge clk) begin
        if (reset || flush)
            md_pend <= 1'b0;
        else if (mul.start || div.start)
            md_pend <= 1'b1;
        else if (md_done)
            md_pend <= 1'b0;
    end

    assign stall = e_valid & (is_md_mul | is_md_div) & ~md_done
                   & (e_new | (md_pend & md_busy));
    assign result_valid = e_valid & ~stall & ~flush;
    assign hilo_we_hi   = result_valid & (is_mthi | is_md_mul | is_md_div);
    assign hilo_we_lo   = result_valid & (is_mtlo | is_md_mul | is_md_div);

endmodule

`default_nettype wire

//--- hdl/div_radix2.sv
`timescale 1ns/1ps
`default_nettype none

module div_radix2 (
    input  wire    clk,
    input  wire    reset,
    input  wire    flush,
    muldiv_if.unit bus
);
    import ex_pkg::*;

    div_state_t           state;
    logic [DIV_CNT_W-1:0] cnt;
    word_t                rem, quo, dvs;
    word_t                a_mag, b_mag;
    logic                 q_neg, r_neg;
    logic [32:0]          rshift;
    logic [33:0]          diff;

    assign a_mag  = (bus.sign & bus.a[31]) ? -bus.a : bus.a;
    assign b_mag  = (bus.sign & bus.b[31]) ? -bus.b : bus.b;
    assign rshift = {rem, quo[31]};
    assign diff   = {1'b0, rshift} - {2'b0, dvs};   // msb set means restore

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    cnt <= '0;
                    if (bus.start)
                        state <= DIV_RUN;
                end
                DIV_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == DIV_CNT_W'(DIV_CYCLES - 1))
                        state <= DIV_FIX;
                end
                DIV_FIX:    state <= DIV_FINISH;
                default:    state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            DIV_IDLE: begin
                if (bus.start) begin
                    rem   <= '0;
                    quo   <= a_mag;
                    dvs   <= b_mag;
                    q_neg <= bus.sign & (bus.a[31] ^ bus.b[31]);
                    r_neg <= bus.sign & bus.a[31];   // remainder follows dividend
                end
            end
            DIV_RUN: begin
                if (diff[33]) begin
                    rem <= rshift[31:0];
                    quo <= {quo[30:0], 1'b0};
                end else begin
                    rem <= diff[31:0];
                    quo <= {quo[30:0], 1'b1};
                end
            end
            DIV_FIX: begin
                if (q_neg)
                    quo <= -quo;
                if (r_neg)
                    rem <= -rem;
            end
            default: ;
        endcase
    end

    assign bus.busy   = (state != DIV_IDLE);
    assign bus.done   = (state == DIV_FINISH);
    assign bus.result = {rem, quo};

endmodule

`default_nettype wire

//--- hdl/ex_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_reg (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  issue,
    input  wire ex_pkg::alu_op_t op,
    input  wire ex_pkg::word_t   src_a,
    input  wire ex_pkg::word_t   src_b,
    input  wire ex_pkg::shamt_t  sa,
    input  wire                  flush,
    input  wire                  stall,
    output logic                 e_valid,
    output ex_pkg::alu_op_t      e_op,
    output ex_pkg::word_t        e_a,
    output ex_pkg::word_t        e_b,
    output ex_pkg::shamt_t       e_sa,
    output logic                 e_new
);
    import ex_pkg::*;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            e_valid <= 1'b0;
            e_new   <= 1'b0;
        end else if (!stall) begin
            e_valid <= issue;
            e_new   <= issue;   // first cycle of this instruction
        end else begin
            e_new   <= 1'b0;    // held, already seen
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && issue) begin
            e_op <= op;
            e_a  <= src_a;
            e_b  <= src_b;
            e_sa <= sa;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ex_pkg.sv
`default_nettype none

package ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [4:0]  alu_op_t;
    typedef logic [4:0]  shamt_t;

    localparam alu_op_t OP_AND    = 5'd0;
    localparam alu_op_t OP_OR     = 5'd1;
    localparam alu_op_t OP_NOR    = 5'd2;
    localparam alu_op_t OP_XOR    = 5'd3;
    localparam alu_op_t OP_ADD    = 5'd4;   // traps on overflow
    localparam alu_op_t OP_ADDU   = 5'd5;
    localparam alu_op_t OP_SUB    = 5'd6;   // traps on overflow
    localparam alu_op_t OP_SUBU   = 5'd7;
    localparam alu_op_t OP_SLT    = 5'd8;
    localparam alu_op_t OP_SLTU   = 5'd9;
    localparam alu_op_t OP_SLL    = 5'd10;  // amount from rs
    localparam alu_op_t OP_SRL    = 5'd11;
    localparam alu_op_t OP_SRA    = 5'd12;
    localparam alu_op_t OP_SLL_SA = 5'd13;  // amount from sa field
    localparam alu_op_t OP_SRL_SA = 5'd14;
    localparam alu_op_t OP_SRA_SA = 5'd15;
    localparam alu_op_t OP_LUI    = 5'd16;
    localparam alu_op_t OP_PASS   = 5'd17;
    localparam alu_op_t OP_MTHI   = 5'd18;
    localparam alu_op_t OP_MTLO   = 5'd19;
    localparam alu_op_t OP_MULT   = 5'd20;
    localparam alu_op_t OP_MULTU  = 5'd21;
    localparam alu_op_t OP_DIV    = 5'd22;
    localparam alu_op_t OP_DIVU   = 5'd23;

    localparam int MULT_CYCLES = 8;    // one 4-bit digit per cycle
    localparam int DIV_CYCLES  = 32;   // one quotient bit per cycle
    localparam int MULT_CNT_W  = $clog2(MULT_CYCLES + 1);
    localparam int DIV_CNT_W   = $clog2(DIV_CYCLES);

    // divider sequencer
    typedef logic [1:0] div_state_t;
    localparam div_state_t DIV_IDLE   = 2'd0;
    localparam div_state_t DIV_RUN    = 2'd1;
    localparam div_state_t DIV_FIX    = 2'd2;
    localparam div_state_t DIV_FINISH = 2'd3;

endpackage

`default_nettype wire

//--- hdl/ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module ex_top (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  issue,
    input  wire ex_pkg::alu_op_t op,
    input  wire ex_pkg::word_t   src_a,
    input  wire ex_pkg::word_t   src_b,
    input  wire ex_pkg::shamt_t  sa,
    input  wire                  flush,
    output logic                 stall,
    output ex_pkg::dword_t       result,
    output logic                 overflow,
    output logic                 result_valid,
    output ex_pkg::word_t        hi,
    output ex_pkg::word_t        lo
);
    import ex_pkg::*;

    logic    e_valid, e_new, we_hi, we_lo;
    alu_op_t e_op;
    word_t   e_a, e_b;
    shamt_t  e_sa;
    dword_t  hilo;

    muldiv_if mul_bus ();
    muldiv_if div_bus ();

    ex_pipe_reg u_pipe (
        .clk(clk), .reset(reset), .issue(issue), .op(op), .src_a(src_a), .src_b(src_b),
        .sa(sa), .flush(flush), .stall(stall), .e_valid(e_valid), .e_op(e_op),
        .e_a(e_a), .e_b(e_b), .e_sa(e_sa), .e_new(e_new)
    );

    alu_exec u_alu (
        .clk(clk), .reset(reset), .e_valid(e_valid), .e_op(e_op), .e_a(e_a), .e_b(e_b),
        .e_sa(e_sa), .e_new(e_new), .flush(flush), .hilo(hilo), .mul(mul_bus.ctrl),
        .div(div_bus.ctrl), .stall(stall), .result(result), .overflow(overflow),
        .result_valid(result_valid), .hilo_we_hi(we_hi), .hilo_we_lo(we_lo)
    );

    mult_iter u_mult (.clk(clk), .reset(reset), .flush(flush), .bus(mul_bus.unit));

    div_radix2 u_div (.clk(clk), .reset(reset), .flush(flush), .bus(div_bus.unit));

    hilo_regs u_hilo (
        .clk(clk), .reset(reset), .we_hi(we_hi), .we_lo(we_lo), .wdata(result), .hilo(hilo)
    );

    assign hi = hilo[63:32];
    assign lo = hilo[31:0];

endmodule

`default_nettype wire

//--- hdl/hilo_regs.sv
`timescale 1ns/1ps
`default_nettype none

module hilo_regs (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 we_hi,
    input  wire                 we_lo,
    input  wire ex_pkg::dword_t wdata,
    output ex_pkg::dword_t      hilo
);
    import ex_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            hilo <= '0;
        end else begin
            if (we_hi)
                hilo[63:32] <= wdata[63:32];
            if (we_lo)
                hilo[31:0]  <= wdata[31:0];
        end
    end

endmodule

`default_nettype wire

//--- hdl/muldiv_if.sv
`timescale 1ns/1ps
`default_nettype none

interface muldiv_if;
    import ex_pkg::*;

    logic   start;   // one-cycle pulse
    logic   sign;    // 1 for signed op
    word_t  a;
    word_t  b;
    logic   busy;
    logic   done;    // one-cycle pulse
    dword_t result;

    modport ctrl (output start, sign, a, b, input busy, done, result);
    modport unit (input start, sign, a, b, output busy, done, result);

endinterface

`default_nettype wire

//--- hdl/mult_iter.sv
`timescale 1ns/1ps
`default_nettype none

module mult_iter (
    input  wire    clk,
    input  wire    reset,
    input  wire    flush,
    muldiv_if.unit bus
);
    import ex_pkg::*;

    logic                  running;
    logic                  last;
    logic [MULT_CNT_W-1:0] cnt;
    logic                  neg;
    word_t                 a_mag, b_mag, a_hold, b_rest;
    logic [35:0]           partial;
    dword_t                acc;

    assign a_mag = (bus.sign & bus.a[31]) ? -bus.a : bus.a;
    assign b_mag = (bus.sign & bus.b[31]) ? -bus.b : bus.b;
    assign last  = running & (cnt == MULT_CNT_W'(MULT_CYCLES));

    // top digit first, the start cycle does digit 0
    assign partial = running ? a_hold * b_rest[31:28] : a_mag * b_mag[31:28];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            running <= 1'b0;
            cnt     <= '0;
        end else if (bus.start) begin
            running <= 1'b1;
            cnt     <= MULT_CNT_W'(1);
        end else if (last) begin
            running <= 1'b0;
        end else if (running) begin
            cnt     <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            a_hold <= a_mag;
            b_rest <= {b_mag[27:0], 4'b0};
            acc    <= {28'b0, partial};
            neg    <= bus.sign & (bus.a[31] ^ bus.b[31]);
        end else if (running && !last) begin
            b_rest <= {b_rest[27:0], 4'b0};
            acc    <= {acc[59:0], 4'b0} + {28'b0, partial};
        end
    end

    assign bus.busy   = running;
    assign bus.done   = last;
    assign bus.result = neg ? -acc : acc;

endmodule

`default_nettype wire

//--- project.f
hdl/ex_pkg.sv
hdl/muldiv_if.sv
hdl/ex_pipe_reg.sv
hdl/alu_exec.sv
hdl/div_radix2.sv
hdl/mult_iter.sv
hdl/hilo_regs.sv
hdl/ex_top.sv
bench/tb_clock.sv
bench/tb_ex_top.sv
